//--- bench/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// One row of the encoding table. Bits under the mask must equal the value.
typedef struct packed {
  a64_decode_pkg::opcode_t op;
  logic [31:0]             value;
  logic [31:0]             mask;
} pattern_t;

localparam int NUM_PATTERNS = 33;

// Rows in priority order, the first hit wins.
function automatic pattern_t pattern_row(input int idx);
  case (idx)
    0:  return '{a64_decode_pkg::OP_STUR,   32'hF800_0000, 32'hFFE0_0C00};
    1:  return '{a64_decode_pkg::OP_LDUR,   32'hF840_0000, 32'hFFE0_0C00};
    2:  return '{a64_decode_pkg::OP_LDP,    32'hA8C0_0000, 32'hFFC0_0000};
    3:  return '{a64_decode_pkg::OP_STP,    32'hA900_0000, 32'hFFC0_0000};
    4:  return '{a64_decode_pkg::OP_MOVZ,   32'hD280_0000, 32'hFF80_0000};
    5:  return '{a64_decode_pkg::OP_MOVK,   32'hF280_0000, 32'hFF80_0000};
    6:  return '{a64_decode_pkg::OP_ADR,    32'h1000_0000, 32'h9F00_0000};
    7:  return '{a64_decode_pkg::OP_ADRP,   32'h9000_0000, 32'h9F00_0000};
    8:  return '{a64_decode_pkg::OP_CSINC,  32'h9A80_0400, 32'hFFE0_0C00};
    9:  return '{a64_decode_pkg::OP_CSINV,  32'hDA80_0000, 32'hFFE0_0C00};
    10: return '{a64_decode_pkg::OP_CSNEG,  32'hDA80_0400, 32'hFFE0_0C00};
    11: return '{a64_decode_pkg::OP_CSEL,   32'h9A80_0000, 32'hFFE0_0C00};
    12: return '{a64_decode_pkg::OP_ADD,    32'h9100_0000, 32'hFF80_0000};
    13: return '{a64_decode_pkg::OP_ADDS,   32'hAB00_0000, 32'hFFE0_0000};
    14: return '{a64_decode_pkg::OP_SUB,    32'hD100_0000, 32'hFF80_0000};
    15: return '{a64_decode_pkg::OP_SUBS,   32'hEB00_0000, 32'hFFE0_0000};
    16: return '{a64_decode_pkg::OP_ORN,    32'hAA20_0000, 32'hFFE0_0000};
    17: return '{a64_decode_pkg::OP_ORR,    32'hAA00_0000, 32'hFFE0_0000};
    18: return '{a64_decode_pkg::OP_EOR,    32'hCA00_0000, 32'hFFE0_0000};
    19: return '{a64_decode_pkg::OP_AND,    32'h9200_0000, 32'hFFC0_0000};
    20: return '{a64_decode_pkg::OP_ANDS,   32'hEA00_0000, 32'hFFE0_0000};
    21: return '{a64_decode_pkg::OP_UBFM,   32'hD340_0000, 32'hFFC0_0000};
    22: return '{a64_decode_pkg::OP_SBFM,   32'h9340_0000, 32'hFFC0_0000};
    23: return '{a64_decode_pkg::OP_B,      32'h1400_0000, 32'hFC00_0000};
    24: return '{a64_decode_pkg::OP_B_COND, 32'h5400_0000, 32'hFF00_0010};
    25: return '{a64_decode_pkg::OP_BL,     32'h9400_0000, 32'hFC00_0000};
    26: return '{a64_decode_pkg::OP_BLR,    32'hD63F_0000, 32'hFFFF_FC1F};
    27: return '{a64_decode_pkg::OP_BR,     32'hD61F_0000, 32'hFFFF_FC1F};
    28: return '{a64_decode_pkg::OP_CBNZ,   32'hB500_0000, 32'hFF00_0000};
    29: return '{a64_decode_pkg::OP_CBZ,    32'hB400_0000, 32'hFF00_0000};
    30: return '{a64_decode_pkg::OP_RET,    32'hD65F_0000, 32'hFFFF_FC1F};
    31: return '{a64_decode_pkg::OP_NOP,    32'hD503_201F, 32'hFFFF_FFFF};
    // Last row, HLT.
    default: return '{a64_decode_pkg::OP_HLT, 32'hD440_0000, 32'hFFE0_001F};
  endcase
endfunction

function automatic a64_decode_pkg::opcode_t match_opcode(input logic [31:0] insn);
  pattern_t row;
  for (int i = 0; i < NUM_PATTERNS; i++) begin
    row = pattern_row(i);
    if ((insn & row.mask) == row.value)
      return row.op;
  end
  return a64_decode_pkg::OP_ERR;
endfunction

function automatic a64_decode_pkg::reg_slot_t make_slot(input logic [4:0] idx,
                                                        input a64_decode_pkg::reg_status_t st);
  return '{idx: idx, status: st};
endfunction

// Full expected output for one captured word and PC.
function automatic a64_decode_pkg::decode_bundle_t expect_bundle(input logic [31:0] insn,
                                                                 input logic [63:0] pc);
  a64_decode_pkg::decode_bundle_t want;
  a64_decode_pkg::opcode_t        op;
  logic                           is_select;
  op = match_opcode(insn);
  is_select = op inside {a64_decode_pkg::OP_CSEL, a64_decode_pkg::OP_CSINC,
                         a64_decode_pkg::OP_CSINV, a64_decode_pkg::OP_CSNEG};
  want.done = 1'b1;
  want.pc = pc;
  want.opcode = op;
  // Immediates, sign extended through a signed cast where the field is an offset.
  case (op)
    a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_STUR:
      want.operands.imm = 64'($signed(insn[20:12]));
    a64_decode_pkg::OP_ADD, a64_decode_pkg::OP_SUB, a64_decode_pkg::OP_UBFM:
      want.operands.imm = 64'(insn[21:10]);
    a64_decode_pkg::OP_SBFM: want.operands.imm = 64'($signed(insn[21:10]));
    a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ: want.operands.imm = 64'(insn[20:5]);
    a64_decode_pkg::OP_ADR: want.operands.imm = 64'($signed({insn[23:5], insn[30:29]}));
    a64_decode_pkg::OP_ADRP:
      want.operands.imm = 64'($signed({insn[23:5], insn[30:29]})) << 12;
    a64_decode_pkg::OP_B, a64_decode_pkg::OP_BL:
      want.operands.imm = 64'($signed(insn[25:0])) << 2;
    a64_decode_pkg::OP_B_COND, a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ:
      want.operands.imm = 64'($signed(insn[23:5])) << 2;
    default: want.operands.imm = 64'd0;
  endcase
  want.operands.dst  = make_slot(insn[4:0], a64_decode_pkg::REG_IS_USED);
  want.operands.src1 = make_slot(insn[9:5], a64_decode_pkg::REG_IS_USED);
  want.operands.src2 = make_slot(5'd31, a64_decode_pkg::REG_IS_UNUSED);
  if (op inside {a64_decode_pkg::OP_B, a64_decode_pkg::OP_BR, a64_decode_pkg::OP_B_COND,
                 a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ, a64_decode_pkg::OP_RET,
                 a64_decode_pkg::OP_NOP, a64_decode_pkg::OP_HLT, a64_decode_pkg::OP_ERR})
    want.operands.dst = make_slot(5'd31, a64_decode_pkg::REG_IS_UNUSED);
  if (op == a64_decode_pkg::OP_STUR)
    want.operands.dst = make_slot(5'd31, a64_decode_pkg::REG_IS_STUR);
  if (op inside {a64_decode_pkg::OP_BL, a64_decode_pkg::OP_BLR})
    want.operands.dst = make_slot(5'd30, a64_decode_pkg::REG_IS_USED);
  if (op inside {a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ, a64_decode_pkg::OP_ADR,
                 a64_decode_pkg::OP_ADRP, a64_decode_pkg::OP_B, a64_decode_pkg::OP_BL,
                 a64_decode_pkg::OP_NOP, a64_decode_pkg::OP_HLT})
    want.operands.src1 = make_slot(5'd31, a64_decode_pkg::REG_IS_UNUSED);
  if (op == a64_decode_pkg::OP_B_COND)
    want.operands.src1 = make_slot(5'd31, a64_decode_pkg::REG_IS_PC);
  if (op inside {a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ})
    want.operands.src1 = make_slot(insn[4:0], a64_decode_pkg::REG_IS_USED);
  if (op == a64_decode_pkg::OP_STUR)
    want.operands.src2 = make_slot(insn[4:0], a64_decode_pkg::REG_IS_USED);
  if (is_select || op inside {a64_decode_pkg::OP_ADDS, a64_decode_pkg::OP_SUBS,
                              a64_decode_pkg::OP_ORN, a64_decode_pkg::OP_ORR,
                              a64_decode_pkg::OP_EOR, a64_decode_pkg::OP_ANDS})
    want.operands.src2 = make_slot(insn[20:16], a64_decode_pkg::REG_IS_USED);
  if (op inside {a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP,
                 a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ, a64_decode_pkg::OP_ADR,
                 a64_decode_pkg::OP_ADRP, a64_decode_pkg::OP_ADD, a64_decode_pkg::OP_SUB,
                 a64_decode_pkg::OP_AND, a64_decode_pkg::OP_UBFM, a64_decode_pkg::OP_SBFM,
                 a64_decode_pkg::OP_B, a64_decode_pkg::OP_B_COND, a64_decode_pkg::OP_BL})
    want.operands.src2 = make_slot(5'd31, a64_decode_pkg::REG_IS_IMMEDIATE);
  case (op)
    a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP, a64_decode_pkg::OP_ADD,
    a64_decode_pkg::OP_ADDS: want.control.fu_op = a64_decode_pkg::FU_OP_PLUS;
    a64_decode_pkg::OP_SUB, a64_decode_pkg::OP_SUBS: want.control.fu_op = a64_decode_pkg::FU_OP_MINUS;
    a64_decode_pkg::OP_LDUR:  want.control.fu_op = a64_decode_pkg::FU_OP_LDUR;
    a64_decode_pkg::OP_STUR:  want.control.fu_op = a64_decode_pkg::FU_OP_STUR;
    a64_decode_pkg::OP_ORN:   want.control.fu_op = a64_decode_pkg::FU_OP_ORN;
    a64_decode_pkg::OP_ORR:   want.control.fu_op = a64_decode_pkg::FU_OP_OR;
    a64_decode_pkg::OP_EOR:   want.control.fu_op = a64_decode_pkg::FU_OP_EOR;
    a64_decode_pkg::OP_AND, a64_decode_pkg::OP_ANDS: want.control.fu_op = a64_decode_pkg::FU_OP_AND;
    a64_decode_pkg::OP_UBFM:  want.control.fu_op = a64_decode_pkg::FU_OP_UBFM;
    a64_decode_pkg::OP_SBFM:  want.control.fu_op = a64_decode_pkg::FU_OP_SBFM;
    a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ: want.control.fu_op = a64_decode_pkg::FU_OP_MOV;
    a64_decode_pkg::OP_CSEL:  want.control.fu_op = a64_decode_pkg::FU_OP_CSEL;
    a64_decode_pkg::OP_CSINC: want.control.fu_op = a64_decode_pkg::FU_OP_CSINC;
    a64_decode_pkg::OP_CSINV: want.control.fu_op = a64_decode_pkg::FU_OP_CSINV;
    a64_decode_pkg::OP_B_COND: want.control.fu_op = a64_decode_pkg::FU_OP_B_COND;
    a64_decode_pkg::OP_ADR, a64_decode_pkg::OP_ADRP: want.control.fu_op = a64_decode_pkg::FU_OP_ADRX;
    default: want.control.fu_op = a64_decode_pkg::FU_OP_PASS_A;
  endcase
  want.control.fu_id = (op inside {a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_STUR,
                                   a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP}) ?
                       a64_decode_pkg::FU_LS : a64_decode_pkg::FU_ALU;
  if (op == a64_decode_pkg::OP_B_COND)
    want.control.cond = a64_decode_pkg::cond_t'(insn[3:0]);
  else if (is_select)
    want.control.cond = a64_decode_pkg::cond_t'(insn[15:12]);
  else
    want.control.cond = a64_decode_pkg::COND_EQ;
  want.control.set_nzcv = op inside {a64_decode_pkg::OP_ADDS, a64_decode_pkg::OP_SUBS,
                                     a64_decode_pkg::OP_ANDS};
  want.control.uses_nzcv = is_select || (op == a64_decode_pkg::OP_B_COND);
  want.control.mispredict = op inside {a64_decode_pkg::OP_BR, a64_decode_pkg::OP_BLR,
                                       a64_decode_pkg::OP_RET};
  want.control.bcond = (op == a64_decode_pkg::OP_B_COND);
  return want;
endfunction

`endif

//--- bench/tb_a64_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "a64_decode_macros.svh"

module tb_a64_decode;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int TEST_CYCLES  = 3000;

  logic                           in_clk;
  logic                           in_rst;
  a64_decode_pkg::fetch_bundle_t  fetch;
  a64_decode_pkg::decode_bundle_t decoded;

  // Expected results wait one cycle here. The flag marks a full compare.
  a64_decode_pkg::decode_bundle_t expected_q[$];
  bit                             full_q[$];

  `include "decode_ref_model.svh"

  a64_decode_stage uut (
    .in_clk  (in_clk),
    .in_rst  (in_rst),
    .fetch   (fetch),
    .decoded (decoded)
  );

  always #(CLK_PERIOD / 2) in_clk = ~in_clk;

  task automatic report_mismatch(input string field, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h", $time, field, got, want);
    $display("Test failures found");
    $fatal(1, "Decoded output differs from the reference model");
  endtask

  task automatic check_done(input logic got, input logic want);
    if (got !== want)
      report_mismatch("done", 64'(got), 64'(want));
  endtask

  task automatic check_bundle(input a64_decode_pkg::decode_bundle_t got,
                              input a64_decode_pkg::decode_bundle_t want);
    check_done(got.done, want.done);
    if (got.pc !== want.pc)
      report_mismatch("pc", got.pc, want.pc);
    if (got.opcode !== want.opcode)
      report_mismatch("opcode", 64'(got.opcode), 64'(want.opcode));
    if (got.operands.imm !== want.operands.imm)
      report_mismatch("imm", got.operands.imm, want.operands.imm);
    if (got.operands.src1 !== want.operands.src1)
      report_mismatch("src1", 64'(got.operands.src1), 64'(want.operands.src1));
    if (got.operands.src2 !== want.operands.src2)
      report_mismatch("src2", 64'(got.operands.src2), 64'(want.operands.src2));
    if (got.operands.dst !== want.operands.dst)
      report_mismatch("dst", 64'(got.operands.dst), 64'(want.operands.dst));
    if (got.control !== want.control)
      report_mismatch("control", 64'(got.control), 64'(want.control));
  endtask

  // Before the first strobe the captured word is unknown, so only done is compared.
  task automatic compare_oldest();
    a64_decode_pkg::decode_bundle_t want;
    bit                             full;
    want = expected_q.pop_front();
    full = full_q.pop_front();
    if (full)
      check_bundle(decoded, want);
    else
      check_done(decoded.done, want.done);
  endtask

  initial begin
    a64_decode_pkg::decode_bundle_t last_item;
    pattern_t                       row;
    logic [31:0]                    insn;
    logic [63:0]                    pc;
    int unsigned                    choice;
    bit                             have_item;
    in_clk    = 1'b0;
    in_rst    = 1'b1;
    fetch     = '0;
    have_item = 1'b0;
    void'($urandom(32'h4cd6));
    repeat (RESET_CYCLES) @(posedge in_clk);
    in_rst <= 1'b0;
    @(negedge in_clk);
    check_done(decoded.done, 1'b0);
    // Each cycle sends a table pattern, a raw random word or nothing.
    for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
      @(posedge in_clk);
      choice = $urandom % 3;
      row    = pattern_row(int'($urandom % NUM_PATTERNS));
      insn   = (choice == 0) ? (row.value | ($urandom & ~row.mask)) : $urandom;
      pc     = {$urandom, $urandom};
      fetch <= '{done: (choice != 2), insn: insn, pc: pc};
      if (choice != 2) begin
        last_item = expect_bundle(insn, pc);
        have_item = 1'b1;
      end else begin
        last_item.done = 1'b0;
      end
      expected_q.push_back(last_item);
      full_q.push_back(have_item);
      @(negedge in_clk);
      if (expected_q.size() > 1)
        compare_oldest();
    end
    @(posedge in_clk);
    fetch.done <= 1'b0;
    @(negedge in_clk);
    compare_oldest();
    // With no strobe left, done falls one cycle later.
    @(posedge in_clk);
    @(negedge in_clk);
    check_done(decoded.done, 1'b0);
    $display("All tests passed!");
    $finish;
  end

  // Covers reset, every test cycle and a small margin.
  initial begin
    #((RESET_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD);
    $display("Test failures found");
    $fatal(1, "The run timed out before all results were checked");
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
+incdir+bench
hdl/a64_decode_pkg.sv
hdl/a64_opcode_matcher.sv
hdl/a64_operand_extractor.sv
hdl/a64_control_decoder.sv
hdl/a64_decode_stage.sv
bench/tb_a64_decode.sv

//--- hdl/a64_control_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "a64_decode_macros.svh"

module a64_control_decoder (
  input  wire logic [`A64_INSN_BITS-1:0] insn,
  input  wire a64_decode_pkg::opcode_t   opcode,
  output a64_decode_pkg::control_bundle_t control
);

  a64_decode_pkg::fu_t    fu_id;
  a64_decode_pkg::fu_op_t fu_op;
  a64_decode_pkg::cond_t  cond;
  logic                   is_csel_family;

  assign is_csel_family = (opcode == a64_decode_pkg::OP_CSEL)  ||
                          (opcode == a64_decode_pkg::OP_CSINC) ||
                          (opcode == a64_decode_pkg::OP_CSINV) ||
                          (opcode == a64_decode_pkg::OP_CSNEG);

  // Operation for the functional unit.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP,
      a64_decode_pkg::OP_ADD, a64_decode_pkg::OP_ADDS: fu_op = a64_decode_pkg::FU_OP_PLUS;
      a64_decode_pkg::OP_SUB, a64_decode_pkg::OP_SUBS: fu_op = a64_decode_pkg::FU_OP_MINUS;
      a64_decode_pkg::OP_LDUR:  fu_op = a64_decode_pkg::FU_OP_LDUR;
      a64_decode_pkg::OP_STUR:  fu_op = a64_decode_pkg::FU_OP_STUR;
      a64_decode_pkg::OP_ORN:   fu_op = a64_decode_pkg::FU_OP_ORN;
      a64_decode_pkg::OP_ORR:   fu_op = a64_decode_pkg::FU_OP_OR;
      a64_decode_pkg::OP_EOR:   fu_op = a64_decode_pkg::FU_OP_EOR;
      a64_decode_pkg::OP_AND, a64_decode_pkg::OP_ANDS: fu_op = a64_decode_pkg::FU_OP_AND;
      a64_decode_pkg::OP_UBFM:  fu_op = a64_decode_pkg::FU_OP_UBFM;
      a64_decode_pkg::OP_SBFM:  fu_op = a64_decode_pkg::FU_OP_SBFM;
      a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ: fu_op = a64_decode_pkg::FU_OP_MOV;
      a64_decode_pkg::OP_CSEL:  fu_op = a64_decode_pkg::FU_OP_CSEL;
      a64_decode_pkg::OP_CSINC: fu_op = a64_decode_pkg::FU_OP_CSINC;
      a64_decode_pkg::OP_CSINV: fu_op = a64_decode_pkg::FU_OP_CSINV;
      a64_decode_pkg::OP_B_COND: fu_op = a64_decode_pkg::FU_OP_B_COND;
      a64_decode_pkg::OP_ADR, a64_decode_pkg::OP_ADRP: fu_op = a64_decode_pkg::FU_OP_ADRX;
      // Register branches and everything else just pass operand A along.
      default:                  fu_op = a64_decode_pkg::FU_OP_PASS_A;
    endcase
  end

  // Memory operations go to the load/store unit.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_STUR,
      a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP: fu_id = a64_decode_pkg::FU_LS;
      default:                                        fu_id = a64_decode_pkg::FU_ALU;
    endcase
  end

  // B.cond keeps its condition in the low nibble, the selects in bits 15:12.
  always_comb begin
    if (opcode == a64_decode_pkg::OP_B_COND) begin
      cond = a64_decode_pkg::cond_t'(insn[3:0]);
    end else if (is_csel_family) begin
      cond = a64_decode_pkg::cond_t'(insn[15:12]);
    end else begin
      cond = a64_decode_pkg::COND_EQ;
    end
  end

  assign control.fu_id      = fu_id;
  assign control.fu_op      = fu_op;
  assign control.cond       = cond;
  assign control.set_nzcv   = (opcode == a64_decode_pkg::OP_ADDS) ||
                              (opcode == a64_decode_pkg::OP_SUBS) ||
                              (opcode == a64_decode_pkg::OP_ANDS);
  assign control.uses_nzcv  = (opcode == a64_decode_pkg::OP_B_COND) || is_csel_family;
  // Register targets are not predicted, so they always resolve late.
  assign control.mispredict = (opcode == a64_decode_pkg::OP_BR)  ||
                              (opcode == a64_decode_pkg::OP_BLR) ||
                              (opcode == a64_decode_pkg::OP_RET);
  assign control.bcond      = (opcode == a64_decode_pkg::OP_B_COND);

endmodule

`default_nettype wire

//--- hdl/a64_decode_macros.svh
`ifndef A64_DECODE_MACROS_SVH
`define A64_DECODE_MACROS_SVH

// Width of one fetched instruction word.
`define A64_INSN_BITS 32

// Width of the immediate and of the program counter.
`define A64_DATA_BITS 64

// Width of a general purpose register number.
`define A64_REG_IDX_BITS 5

// Link register, written by BL and BLR.
`define A64_LINK_REG 5'd30

// Zero register, placed in any register slot that is unused.
`define A64_ZERO_REG 5'd31

`endif

//--- hdl/a64_decode_pkg.sv
`default_nettype none

`include "a64_decode_macros.svh"

package a64_decode_pkg;

  // Decoded instruction class.
  // The order has no meaning beyond OP_ERR being the catch-all.
  typedef enum logic [5:0] {
    OP_LDUR,
    OP_STUR,
    OP_LDP,
    OP_STP,
    OP_MOVK,
    OP_MOVZ,
    OP_ADR,
    OP_ADRP,
    OP_CSEL,
    OP_CSINC,
    OP_CSINV,
    OP_CSNEG,
    OP_ADD,
    OP_ADDS,
    OP_SUB,
    OP_SUBS,
    OP_ORN,
    OP_ORR,
    OP_EOR,
    OP_AND,
    OP_ANDS,
    OP_UBFM,
    OP_SBFM,
    OP_B,
    OP_B_COND,
    OP_BL,
    OP_BLR,
    OP_BR,
    OP_CBZ,
    OP_CBNZ,
    OP_RET,
    OP_NOP,
    OP_HLT,
    OP_ERR
  } opcode_t;

  // Operation handed to the functional unit.
  typedef enum logic [4:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_ORN,
    FU_OP_OR,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_UBFM,
    FU_OP_SBFM,
    FU_OP_MOV,
    FU_OP_CSEL,
    FU_OP_CSINC,
    FU_OP_CSINV,
    FU_OP_PASS_A,
    FU_OP_B_COND,
    FU_OP_ADRX
  } fu_op_t;

  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  // How the rename stage treats a register slot.
  typedef enum logic [2:0] {
    REG_IS_USED,
    REG_IS_UNUSED,
    REG_IS_PC,
    REG_IS_IMMEDIATE,
    REG_IS_STUR
  } reg_status_t;

  // A64 condition codes, in encoding order.
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  typedef struct packed {
    logic [`A64_REG_IDX_BITS-1:0] idx;
    reg_status_t                  status;
  } reg_slot_t;

  typedef struct packed {
    logic                      done;
    logic [`A64_INSN_BITS-1:0] insn;
    logic [`A64_DATA_BITS-1:0] pc;
  } fetch_bundle_t;

  typedef struct packed {
    logic [`A64_DATA_BITS-1:0] imm;
    reg_slot_t                 src1;
    reg_slot_t                 src2;
    reg_slot_t                 dst;
  } operand_bundle_t;

  typedef struct packed {
    fu_t    fu_id;
    fu_op_t fu_op;
    cond_t  cond;
    logic   set_nzcv;
    logic   uses_nzcv;
    logic   mispredict;
    logic   bcond;
  } control_bundle_t;

  // Full output of the decode stage, one per fetch strobe.
  typedef struct packed {
    logic                      done;
    logic [`A64_DATA_BITS-1:0] pc;
    opcode_t                   opcode;
    operand_bundle_t           operands;
    control_bundle_t           control;
  } decode_bundle_t;

endpackage

`default_nettype wire

//--- hdl/a64_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "a64_decode_macros.svh"

module a64_decode_stage (
  input  wire logic                          in_clk,
  input  wire logic                          in_rst,
  input  wire a64_decode_pkg::fetch_bundle_t fetch,
  output a64_decode_pkg::decode_bundle_t     decoded
);

  logic [`A64_INSN_BITS-1:0]        insn_q;
  logic [`A64_DATA_BITS-1:0]        pc_q;
  logic                             done_q;
  a64_decode_pkg::opcode_t          opcode;
  a64_decode_pkg::operand_bundle_t  operands;
  a64_decode_pkg::control_bundle_t  control;

  // Output strobe trails the fetch strobe by one cycle.
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= fetch.done;
    end
  end

  // Word and PC hold between strobes.
  always_ff @(posedge in_clk) begin
    if (fetch.done) begin
      insn_q <= fetch.insn;
      pc_q   <= fetch.pc;
    end
  end

  a64_opcode_matcher u_matcher (
    .insn   (insn_q),
    .opcode (opcode)
  );

  a64_operand_extractor u_operands (
    .insn     (insn_q),
    .opcode   (opcode),
    .operands (operands)
  );

  a64_control_decoder u_control (
    .insn    (insn_q),
    .opcode  (opcode),
    .control (control)
  );

  assign decoded = '{done: done_q, pc: pc_q, opcode: opcode,
                     operands: operands, control: control};

endmodule

`default_nettype wire

//--- hdl/a64_opcode_matcher.sv
`timescale 1ns/1ns
`default_nettype none

`include "a64_decode_macros.svh"

module a64_opcode_matcher (
  input  wire logic [`A64_INSN_BITS-1:0] insn,
  output a64_decode_pkg::opcode_t        opcode
);

  // Entries are checked top to bottom and the first hit wins.
  // Only the 64-bit forms are recognised.
  always_comb begin
    casez (insn)
      // Unscaled register load and store.
      32'b1111_1000_000?_????_????_00??_????_????: opcode = a64_decode_pkg::OP_STUR;
      32'b1111_1000_010?_????_????_00??_????_????: opcode = a64_decode_pkg::OP_LDUR;
      // Register pair, post-index load and signed-offset store.
      32'b1010_1000_11??_????_????_????_????_????: opcode = a64_decode_pkg::OP_LDP;
      32'b1010_1001_00??_????_????_????_????_????: opcode = a64_decode_pkg::OP_STP;
      // Wide moves.
      32'b1101_0010_1???_????_????_????_????_????: opcode = a64_decode_pkg::OP_MOVZ;
      32'b1111_0010_1???_????_????_????_????_????: opcode = a64_decode_pkg::OP_MOVK;
      // PC relative addressing, bit 31 picks the page form.
      32'b0??1_0000_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_ADR;
      32'b1??1_0000_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_ADRP;
      // Conditional selects.
      32'b1001_1010_100?_????_????_01??_????_????: opcode = a64_decode_pkg::OP_CSINC;
      32'b1101_1010_100?_????_????_00??_????_????: opcode = a64_decode_pkg::OP_CSINV;
      32'b1101_1010_100?_????_????_01??_????_????: opcode = a64_decode_pkg::OP_CSNEG;
      32'b1001_1010_100?_????_????_00??_????_????: opcode = a64_decode_pkg::OP_CSEL;
      // Add and subtract, immediate and shifted register forms.
      32'b1001_0001_0???_????_????_????_????_????: opcode = a64_decode_pkg::OP_ADD;
      32'b1010_1011_000?_????_????_????_????_????: opcode = a64_decode_pkg::OP_ADDS;
      32'b1101_0001_0???_????_????_????_????_????: opcode = a64_decode_pkg::OP_SUB;
      32'b1110_1011_000?_????_????_????_????_????: opcode = a64_decode_pkg::OP_SUBS;
      // Logic operations.
      32'b1010_1010_001?_????_????_????_????_????: opcode = a64_decode_pkg::OP_ORN;
      32'b1010_1010_000?_????_????_????_????_????: opcode = a64_decode_pkg::OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: opcode = a64_decode_pkg::OP_EOR;
      32'b1001_0010_00??_????_????_????_????_????: opcode = a64_decode_pkg::OP_AND;
      32'b1110_1010_000?_????_????_????_????_????: opcode = a64_decode_pkg::OP_ANDS;
      // Bitfield moves, the base of LSL, LSR and ASR.
      32'b1101_0011_01??_????_????_????_????_????: opcode = a64_decode_pkg::OP_UBFM;
      32'b1001_0011_01??_????_????_????_????_????: opcode = a64_decode_pkg::OP_SBFM;
      // Immediate branches.
      32'b0001_01??_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_B;
      32'b0101_0100_????_????_????_????_???0_????: opcode = a64_decode_pkg::OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_BL;
      // Register branches.
      32'b1101_0110_0011_1111_0000_00??_???0_0000: opcode = a64_decode_pkg::OP_BLR;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = a64_decode_pkg::OP_BR;
      // Compare and branch.
      32'b1011_0101_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_CBNZ;
      32'b1011_0100_????_????_????_????_????_????: opcode = a64_decode_pkg::OP_CBZ;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = a64_decode_pkg::OP_RET;
      // System hints and halt.
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = a64_decode_pkg::OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: opcode = a64_decode_pkg::OP_HLT;
      default:                                     opcode = a64_decode_pkg::OP_ERR;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/a64_operand_extractor.sv
`timescale 1ns/1ns
`default_nettype none

`include "a64_decode_macros.svh"

module a64_operand_extractor (
  input  wire logic [`A64_INSN_BITS-1:0] insn,
  input  wire a64_decode_pkg::opcode_t   opcode,
  output a64_decode_pkg::operand_bundle_t operands
);

  logic [`A64_DATA_BITS-1:0] imm;
  a64_decode_pkg::reg_slot_t src1;
  a64_decode_pkg::reg_slot_t src2;
  a64_decode_pkg::reg_slot_t dst;

  // Immediate, extended to the full data width.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_STUR:
        imm = {{(`A64_DATA_BITS-9){insn[20]}}, insn[20:12]};
      a64_decode_pkg::OP_ADD, a64_decode_pkg::OP_SUB, a64_decode_pkg::OP_UBFM:
        imm = {{(`A64_DATA_BITS-12){1'b0}}, insn[21:10]};
      a64_decode_pkg::OP_SBFM:
        imm = {{(`A64_DATA_BITS-12){insn[21]}}, insn[21:10]};
      a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ:
        imm = {{(`A64_DATA_BITS-16){1'b0}}, insn[20:5]};
      // immhi:immlo, sign taken from the top of immhi.
      a64_decode_pkg::OP_ADR:
        imm = {{(`A64_DATA_BITS-21){insn[23]}}, insn[23:5], insn[30:29]};
      a64_decode_pkg::OP_ADRP:
        imm = {{(`A64_DATA_BITS-33){insn[23]}}, insn[23:5], insn[30:29], 12'h000};
      a64_decode_pkg::OP_B, a64_decode_pkg::OP_BL:
        imm = {{(`A64_DATA_BITS-28){insn[25]}}, insn[25:0], 2'b00};
      a64_decode_pkg::OP_B_COND, a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ:
        imm = {{(`A64_DATA_BITS-21){insn[23]}}, insn[23:5], 2'b00};
      default:
        imm = '0;
    endcase
  end

  // Destination register.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_B, a64_decode_pkg::OP_BR, a64_decode_pkg::OP_B_COND,
      a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ, a64_decode_pkg::OP_RET,
      a64_decode_pkg::OP_NOP, a64_decode_pkg::OP_HLT, a64_decode_pkg::OP_ERR:
        dst = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_UNUSED};
      a64_decode_pkg::OP_STUR:
        dst = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_STUR};
      a64_decode_pkg::OP_BL, a64_decode_pkg::OP_BLR:
        dst = '{idx: `A64_LINK_REG, status: a64_decode_pkg::REG_IS_USED};
      default:
        dst = '{idx: insn[4:0], status: a64_decode_pkg::REG_IS_USED};
    endcase
  end

  // First source. B.cond reads the flags against the PC, not a register.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ, a64_decode_pkg::OP_ADR,
      a64_decode_pkg::OP_ADRP, a64_decode_pkg::OP_B, a64_decode_pkg::OP_BL,
      a64_decode_pkg::OP_NOP, a64_decode_pkg::OP_HLT:
        src1 = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_UNUSED};
      a64_decode_pkg::OP_B_COND:
        src1 = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_PC};
      a64_decode_pkg::OP_CBZ, a64_decode_pkg::OP_CBNZ:
        src1 = '{idx: insn[4:0], status: a64_decode_pkg::REG_IS_USED};
      default:
        src1 = '{idx: insn[9:5], status: a64_decode_pkg::REG_IS_USED};
    endcase
  end

  // Second source. STUR reads its store data from Rt.
  always_comb begin
    case (opcode)
      a64_decode_pkg::OP_STUR:
        src2 = '{idx: insn[4:0], status: a64_decode_pkg::REG_IS_USED};
      a64_decode_pkg::OP_ADDS, a64_decode_pkg::OP_SUBS, a64_decode_pkg::OP_ORN,
      a64_decode_pkg::OP_ORR, a64_decode_pkg::OP_EOR, a64_decode_pkg::OP_ANDS,
      a64_decode_pkg::OP_CSEL, a64_decode_pkg::OP_CSINC, a64_decode_pkg::OP_CSINV,
      a64_decode_pkg::OP_CSNEG:
        src2 = '{idx: insn[20:16], status: a64_decode_pkg::REG_IS_USED};
      a64_decode_pkg::OP_LDUR, a64_decode_pkg::OP_LDP, a64_decode_pkg::OP_STP,
      a64_decode_pkg::OP_MOVK, a64_decode_pkg::OP_MOVZ, a64_decode_pkg::OP_ADR,
      a64_decode_pkg::OP_ADRP, a64_decode_pkg::OP_ADD, a64_decode_pkg::OP_SUB,
      a64_decode_pkg::OP_AND, a64_decode_pkg::OP_UBFM, a64_decode_pkg::OP_SBFM,
      a64_decode_pkg::OP_B, a64_decode_pkg::OP_B_COND, a64_decode_pkg::OP_BL:
        src2 = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_IMMEDIATE};
      default:
        src2 = '{idx: `A64_ZERO_REG, status: a64_decode_pkg::REG_IS_UNUSED};
    endcase
  end

  assign operands = '{imm: imm, src1: src1, src2: src2, dst: dst};

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_a64_decode \
  -f compile.f \
  -o tb_a64_decode

./obj_dir/tb_a64_decode 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
